// File: hdl/mdll_pkg.sv
// mdll shared package with delay path sizes, control types and the register map
package mdll_pkg;

  // ------------------------------------------------------------
  // delay path geometry
  // ------------------------------------------------------------
  localparam int N_STG    = 8;              // coarse stages per lane
  localparam int TD       = 2;              // unit delay in samples
  localparam int STG_DLY  = 2 * TD;         // one coarse stage = two unit cells
  localparam int FINE_MAX = 3;              // fine line reach in samples
  localparam int CODE_MAX = N_STG * STG_DLY + FINE_MAX;
  localparam int PATH_LAT = 2;              // coarse reg + fine reg
  localparam int LOCK_N   = 4;              // alternating pulses for lock

  // ------------------------------------------------------------
  // typed vectors
  // ------------------------------------------------------------
  typedef logic [N_STG-1:0] thm_t;          // coarse thermometer, lsb first
  typedef logic [1:0]       fine_t;         // fine tap select
  typedef logic [5:0]       dly_code_t;     // {stage count, fine}
  typedef logic [2:0]       gain_t;         // loop step
  typedef logic [1:0]       reg_addr_t;
  typedef logic [7:0]       reg_data_t;

  // ------------------------------------------------------------
  // register map
  // ------------------------------------------------------------
  localparam reg_addr_t REG_CTRL     = 2'd0;
  localparam reg_addr_t REG_MAN_CODE = 2'd1;
  localparam reg_addr_t REG_GAIN     = 2'd2;
  localparam reg_addr_t REG_STATUS   = 2'd3; // read only

  // bit positions inside CTRL and STATUS
  localparam int CTRL_EN_BIT   = 0;
  localparam int CTRL_MAN_BIT  = 1;
  localparam int STAT_LOCK_BIT = 7;

endpackage

// File: hdl/mdll_ctl_if.sv
// control and status bundle shared by the register block and the loop filter
interface mdll_ctl_if;

  // settings from the register block
  logic                en;       // loop running
  logic                manual;   // code follows man_code
  mdll_pkg::dly_code_t man_code; // requested code in manual mode
  mdll_pkg::gain_t     gain;     // step per detector pulse

  // status back from the loop
  mdll_pkg::dly_code_t code;     // live delay code
  logic                locked;

  // register side
  modport regs (
    output en,
    output manual,
    output man_code,
    output gain,
    input  code,
    input  locked
  );

  // loop filter side
  modport loop (
    input  en,
    input  manual,
    input  man_code,
    input  gain,
    output code,
    output locked
  );

endinterface

// File: hdl/mdll_dcdl_coarse_single.sv
// single-ended coarse delay lane, a tapped shift register steered by thermometer code
module mdll_dcdl_coarse_single (
  input  logic           clk,
  input  logic           rst,
  input  logic           cin,      // sampled clock stream
  input  mdll_pkg::thm_t ctl_thm,  // stage enables, lsb first
  output logic           cout      // delayed stream
);

  localparam int LEN = mdll_pkg::N_STG * mdll_pkg::STG_DLY; // deepest tap
  localparam int CW  = $clog2(mdll_pkg::N_STG + 1);
  localparam int IW  = $clog2(LEN + 1);

  // ------------------------------------------------------------
  // history and tap select
  // ------------------------------------------------------------
  logic [LEN-1:0] sr;        // sr[k] is cin from k+1 cycles back
  logic [LEN:0]   hist;      // hist[k] is cin from k cycles back
  logic [CW-1:0]  n_on;      // stages in the valid prefix
  logic [IW-1:0]  tap_idx;
  logic           run;       // still inside the prefix of ones

  assign hist = {sr, cin};

  // count only the leading ones, a bubble stops it
  always_comb begin
    run  = 1'b1;
    n_on = '0;
    for (int i = 0; i < mdll_pkg::N_STG; i++) begin
      run  = run & ctl_thm[i];
      n_on = n_on + CW'(run);
    end
    tap_idx = IW'(int'(n_on) * mdll_pkg::STG_DLY); // STG_DLY samples per stage
  end

  // ------------------------------------------------------------
  // line and output register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      sr   <= '0;                    // drain the line
      cout <= 1'b0;
    end else begin
      sr   <= {sr[LEN-2:0], cin};
      cout <= hist[tap_idx];         // +1 cycle on top of the tap
    end
  end

endmodule

// File: hdl/mdll_dcdl_coarse.sv
// differential coarse delay line, two matched lanes under one thermometer control
module mdll_dcdl_coarse (
  input  logic           clk,
  input  logic           rst,
  input  logic           cinp,     // positive stream in
  input  logic           cinn,     // negative stream in
  input  mdll_pkg::thm_t ctl_thm,  // shared by both lanes
  output logic           coutp,
  output logic           coutn
);

  // ------------------------------------------------------------
  // lanes
  // ------------------------------------------------------------

  // p lane
  mdll_dcdl_coarse_single i_lane_p (
    .clk     (clk),
    .rst     (rst),
    .cin     (cinp),
    .ctl_thm (ctl_thm),
    .cout    (coutp)
  );

  // n lane, runs on its own so a skew on cinn shows up at coutn
  mdll_dcdl_coarse_single i_lane_n (
    .clk     (clk),
    .rst     (rst),
    .cin     (cinn),
    .ctl_thm (ctl_thm),     // same code keeps both lanes equal
    .cout    (coutn)
  );

  // delay per lane = STG_DLY * leading ones + 1 register

endmodule

// File: hdl/mdll_dcdl_fine.sv
// differential fine delay, 0 to FINE_MAX extra samples under a binary control
module mdll_dcdl_fine (
  input  logic            clk,
  input  logic            rst,
  input  logic            cinp,     // from coarse p lane
  input  logic            cinn,     // from coarse n lane
  input  mdll_pkg::fine_t ctl_fine, // extra samples
  output logic            coutp,
  output logic            coutn
);

  localparam int HL = mdll_pkg::FINE_MAX; // history depth per lane

  // ------------------------------------------------------------
  // per-lane history
  // ------------------------------------------------------------
  logic [1:0]    lane_in;    // [0] p, [1] n
  logic [1:0]    lane_out;
  logic [HL-1:0] hist_q [2]; // [k] is the input from k+1 cycles back
  logic [HL:0]   tap [2];    // tap[l][k] is the input from k cycles back

  assign lane_in = {cinn, cinp};

  always_comb begin
    for (int l = 0; l < 2; l++) begin
      tap[l] = {hist_q[l], lane_in[l]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int l = 0; l < 2; l++) begin
        hist_q[l] <= '0;
      end
      lane_out <= '0;
    end else begin
      for (int l = 0; l < 2; l++) begin
        hist_q[l]   <= {hist_q[l][HL-2:0], lane_in[l]};
        lane_out[l] <= tap[l][ctl_fine];   // ctl_fine + 1 cycles total
      end
    end
  end

  assign coutp = lane_out[0];
  assign coutn = lane_out[1];

endmodule

// File: hdl/mdll_pfd.sv
// bang-bang phase detector, samples the delayed stream at reference rising edges
module mdll_pfd (
  input  logic clk,
  input  logic rst,
  input  logic cref,   // reference stream
  input  logic cdly,   // delayed stream from the line
  output logic up,     // delay too short
  output logic dn      // delay too long
);

  // ------------------------------------------------------------
  // edge detect
  // ------------------------------------------------------------
  logic cref_q;  // previous reference sample
  logic rise;

  assign rise = cref & ~cref_q;

  // ------------------------------------------------------------
  // decision
  // ------------------------------------------------------------
  // cdly still high at the edge means its own rising edge came
  // before the reference one, so the line is short of a period
  always_ff @(posedge clk) begin
    if (rst) begin
      cref_q <= 1'b0;
      up     <= 1'b0;
      dn     <= 1'b0;
    end else begin
      cref_q <= cref;
      up     <= rise & cdly;    // one cycle pulse
      dn     <= rise & ~cdly;   // never together with up
    end
  end

endmodule

// File: hdl/mdll_loop_filter.sv
// loop filter, code accumulator with saturation, code decode and lock detect
module mdll_loop_filter (
  input  logic            clk,
  input  logic            rst,
  input  logic            up,        // from detector
  input  logic            dn,
  mdll_ctl_if.loop        ctl,
  output mdll_pkg::thm_t  ctl_thm,   // to coarse line
  output mdll_pkg::fine_t ctl_fine   // to fine line
);

  localparam int RW = $clog2(mdll_pkg::LOCK_N + 1);
  localparam int FW = $bits(mdll_pkg::fine_t);
  localparam int DW = $bits(mdll_pkg::dly_code_t);

  // ------------------------------------------------------------
  // code accumulator
  // ------------------------------------------------------------
  mdll_pkg::dly_code_t code_q;
  mdll_pkg::dly_code_t code_up;
  mdll_pkg::dly_code_t code_dn;
  mdll_pkg::dly_code_t gain_ext;
  logic [DW:0]         sum_up;     // spare msb for the overflow check
  logic [DW-FW-1:0]    n_stg_on;   // coarse part of the code

  assign gain_ext = mdll_pkg::dly_code_t'(ctl.gain);
  assign sum_up   = {1'b0, code_q} + {1'b0, gain_ext};
  assign code_up  = (sum_up > (DW+1)'(mdll_pkg::CODE_MAX)) ?
                    mdll_pkg::dly_code_t'(mdll_pkg::CODE_MAX) : sum_up[DW-1:0];
  assign code_dn  = (code_q < gain_ext) ? '0 : code_q - gain_ext; // floor at 0

  always_ff @(posedge clk) begin
    if (rst) begin
      code_q <= '0;
    end else if (ctl.en) begin          // en low freezes the code
      if (ctl.manual) begin
        code_q <= ctl.man_code;
      end else if (up) begin
        code_q <= code_up;
      end else if (dn) begin
        code_q <= code_dn;
      end
    end
  end

  // ------------------------------------------------------------
  // lock detect
  // ------------------------------------------------------------
  logic          track;      // closed loop running
  logic          have_last;  // a previous pulse exists
  logic          last_up;    // direction of that pulse
  logic [RW-1:0] run_q;      // alternating pulses so far
  logic          locked_q;

  assign track = ctl.en & ~ctl.manual;

  always_ff @(posedge clk) begin
    if (rst || !track) begin
      have_last <= 1'b0;
      last_up   <= 1'b0;
      run_q     <= '0;
      locked_q  <= 1'b0;
    end else if (up || dn) begin
      have_last <= 1'b1;
      last_up   <= up;
      if (have_last && (up == last_up)) begin
        run_q    <= RW'(1);              // same way twice, start over
        locked_q <= 1'b0;
      end else if (run_q < RW'(mdll_pkg::LOCK_N)) begin
        run_q <= run_q + 1'b1;
        if (run_q == RW'(mdll_pkg::LOCK_N - 1)) begin
          locked_q <= 1'b1;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // decode and status
  // ------------------------------------------------------------
  assign n_stg_on = code_q[DW-1:FW];
  assign ctl_fine = code_q[FW-1:0];

  always_comb begin
    for (int i = 0; i < mdll_pkg::N_STG; i++) begin
      ctl_thm[i] = (i < int'(n_stg_on));  // ones from the lsb up
    end
  end

  assign ctl.code   = code_q;
  assign ctl.locked = locked_q;

endmodule

// File: hdl/mdll_cfg_regs.sv
// register block for loop control with strobe writes and live status readback
module mdll_cfg_regs (
  input  logic                clk,
  input  logic                rst,
  input  logic                wr,     // write strobe
  input  mdll_pkg::reg_addr_t addr,
  input  mdll_pkg::reg_data_t wdata,
  output mdll_pkg::reg_data_t rdata,  // follows addr in the same cycle
  mdll_ctl_if.regs            ctl
);

  localparam int DW = $bits(mdll_pkg::dly_code_t);
  localparam int GW = $bits(mdll_pkg::gain_t);

  // ------------------------------------------------------------
  // storage
  // ------------------------------------------------------------
  logic                en_q;
  logic                man_q;
  mdll_pkg::dly_code_t man_code_q;
  mdll_pkg::gain_t     gain_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      en_q       <= 1'b0;
      man_q      <= 1'b0;
      man_code_q <= '0;
      gain_q     <= mdll_pkg::gain_t'(1);   // smallest useful step
    end else if (wr) begin
      case (addr)
        mdll_pkg::REG_CTRL: begin
          en_q  <= wdata[mdll_pkg::CTRL_EN_BIT];
          man_q <= wdata[mdll_pkg::CTRL_MAN_BIT];
        end
        mdll_pkg::REG_MAN_CODE: begin
          // clamp so the line never sees a code past its reach
          man_code_q <= (wdata > mdll_pkg::reg_data_t'(mdll_pkg::CODE_MAX)) ?
                        mdll_pkg::dly_code_t'(mdll_pkg::CODE_MAX) : wdata[DW-1:0];
        end
        mdll_pkg::REG_GAIN: gain_q <= wdata[GW-1:0];
        default: ;                           // status is read only
      endcase
    end
  end

  // ------------------------------------------------------------
  // readback
  // ------------------------------------------------------------
  always_comb begin
    rdata = '0;
    case (addr)
      mdll_pkg::REG_CTRL: begin
        rdata[mdll_pkg::CTRL_EN_BIT]  = en_q;
        rdata[mdll_pkg::CTRL_MAN_BIT] = man_q;
      end
      mdll_pkg::REG_MAN_CODE: rdata[DW-1:0] = man_code_q;
      mdll_pkg::REG_GAIN:     rdata[GW-1:0] = gain_q;
      default: begin                         // status
        rdata[DW-1:0]                  = ctl.code;
        rdata[mdll_pkg::STAT_LOCK_BIT] = ctl.locked;
      end
    endcase
  end

  // drive the loop
  assign ctl.en       = en_q;
  assign ctl.manual   = man_q;
  assign ctl.man_code = man_code_q;
  assign ctl.gain     = gain_q;

endmodule

// File: hdl/mdll_core.sv
// mdll delay path top level with coarse and fine lines, detector, loop filter and registers
module mdll_core (
  input  logic                clk,
  input  logic                rst,
  input  logic                cinp,    // reference stream, positive
  input  logic                cinn,    // reference stream, negative
  output logic                coutp,   // delayed stream, positive
  output logic                coutn,   // delayed stream, negative
  input  logic                wr,
  input  mdll_pkg::reg_addr_t addr,
  input  mdll_pkg::reg_data_t wdata,
  output mdll_pkg::reg_data_t rdata,
  output logic                locked
);

  // ------------------------------------------------------------
  // internal nets
  // ------------------------------------------------------------
  mdll_ctl_if      ctl ();      // regs to loop bundle
  mdll_pkg::thm_t  ctl_thm;
  mdll_pkg::fine_t ctl_fine;
  logic            crs_p;       // coarse line outputs
  logic            crs_n;
  logic            up;
  logic            dn;

  // ------------------------------------------------------------
  // control side
  // ------------------------------------------------------------
  mdll_cfg_regs i_regs (
    .clk   (clk),
    .rst   (rst),
    .wr    (wr),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata),
    .ctl   (ctl.regs)
  );

  mdll_loop_filter i_loop (
    .clk      (clk),
    .rst      (rst),
    .up       (up),
    .dn       (dn),
    .ctl      (ctl.loop),
    .ctl_thm  (ctl_thm),
    .ctl_fine (ctl_fine)
  );

  // ------------------------------------------------------------
  // delay path, coarse then fine
  // ------------------------------------------------------------
  mdll_dcdl_coarse i_coarse (
    .clk     (clk),
    .rst     (rst),
    .cinp    (cinp),
    .cinn    (cinn),
    .ctl_thm (ctl_thm),
    .coutp   (crs_p),
    .coutn   (crs_n)
  );

  mdll_dcdl_fine i_fine (
    .clk      (clk),
    .rst      (rst),
    .cinp     (crs_p),
    .cinn     (crs_n),
    .ctl_fine (ctl_fine),
    .coutp    (coutp),
    .coutn    (coutn)
  );

  // detector closes the loop on the p side only
  mdll_pfd i_pfd (
    .clk  (clk),
    .rst  (rst),
    .cref (cinp),
    .cdly (coutp),
    .up   (up),
    .dn   (dn)
  );

  assign locked = ctl.locked;

endmodule

// File: tb/mdll_tb.sv
// mdll testbench covering reset state, manual delay, register rules, locking and code hold
module mdll_tb;

  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------------------------------------
  // dut signals
  // ------------------------------------------------------------
  logic                clk  = 1'b0;
  logic                rst;
  logic                cinp = 1'b0;   // stream driver owns these
  logic                cinn = 1'b1;
  logic                coutp;
  logic                coutn;
  logic                wr;
  mdll_pkg::reg_addr_t addr;
  mdll_pkg::reg_data_t wdata;
  mdll_pkg::reg_data_t rdata;
  logic                locked;

  // ------------------------------------------------------------
  // stimulus and checker state
  // ------------------------------------------------------------
  integer      seed      = 32'h77a9;  // $random state
  logic [31:0] rnd;
  logic        use_noise = 1'b1;      // random bits, else square wave
  int          per       = 24;        // square wave period in samples
  int          ph        = 0;         // position inside the period
  logic        armed;                 // comparator enable
  int          exp_dly;               // expected path delay in cycles
  int          cyc       = 0;         // negedge count
  logic        hist_p [64];           // inputs as driven, circular
  logic        hist_n [64];
  logic [5:0]  wp;                    // history write slot
  logic [5:0]  rp;                    // slot expected at the output now

  mdll_core i_mdll_core (
    .clk   (clk),
    .rst   (rst),
    .cinp  (cinp),
    .cinn  (cinn),
    .coutp (coutp),
    .coutn (coutn),
    .wr    (wr),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata),
    .locked(locked)
  );

  always #20 clk = ~clk;  // 40 ns period

  // stream driver, 2 ns after each rising edge
  always @(posedge clk) begin
    #2;
    if (use_noise) begin
      rnd  = $random(seed);
      cinp = rnd[0];
      cinn = rnd[1];                  // n lane gets its own bits
    end else begin
      cinp = (ph < per / 2);          // high for the first half
      cinn = ~cinp;
      ph   = (ph >= per - 1) ? 0 : ph + 1;
    end
  end

  // expected delay from cinp/cinn to coutp/coutn for a given code
  function automatic int ref_delay(input mdll_pkg::dly_code_t code);
    int stages;
    int fine;
    stages = int'(code[5:2]);         // coarse stage count
    fine   = int'(code[1:0]);
    return mdll_pkg::STG_DLY * stages + fine + mdll_pkg::PATH_LAT;
  endfunction

  task automatic abort_run(input string why);
    $display("Checks failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s got %h expected %h", name, got, exp);
      abort_run({"wrong value on ", name});
    end
  endtask

  // ------------------------------------------------------------
  // comparator, outputs are settled at the falling edge
  // ------------------------------------------------------------
  always @(negedge clk) begin
    wp         = 6'(cyc);
    rp         = 6'(cyc - exp_dly);      // input driven exp_dly cycles ago
    hist_p[wp] = cinp;
    hist_n[wp] = cinn;
    if (armed) begin
      check_val("coutp", 32'(coutp), 32'(hist_p[rp]));
      check_val("coutn", 32'(coutn), 32'(hist_n[rp]));
    end
    cyc = cyc + 1;
  end

  // ------------------------------------------------------------
  // bus and wait helpers
  // ------------------------------------------------------------
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic reg_write(input mdll_pkg::reg_addr_t a, input mdll_pkg::reg_data_t d);
    @(posedge clk);
    #2;
    wr    = 1'b1;
    addr  = a;
    wdata = d;
    @(posedge clk);                   // write lands here
    #2;
    wr    = 1'b0;
  endtask

  task automatic reg_read(input mdll_pkg::reg_addr_t a, output mdll_pkg::reg_data_t d);
    @(posedge clk);
    #2;
    addr = a;
    @(negedge clk);                   // rdata is combinational
    d = rdata;
  endtask

  task automatic wait_lock(input int limit);
    int n;
    n = 0;
    while (locked !== 1'b1) begin
      @(negedge clk);
      n = n + 1;
      if (n > limit) begin
        abort_run("timeout while waiting for locked to rise");
      end
    end
  endtask

  // ------------------------------------------------------------
  // test steps
  // ------------------------------------------------------------
  task automatic run_manual(input mdll_pkg::dly_code_t code);
    armed = 1'b0;
    reg_write(mdll_pkg::REG_MAN_CODE, 8'(code));
    reg_write(mdll_pkg::REG_CTRL, 8'h03);      // en and manual
    exp_dly = ref_delay(code);
    wait_cycles(2 * mdll_pkg::CODE_MAX + 8);   // let the new tap settle
    armed = 1'b1;
    wait_cycles(120);
    armed = 1'b0;
  endtask

  task automatic run_lock(input mdll_pkg::gain_t g, input int period,
                          input mdll_pkg::dly_code_t start);
    int                  diff;
    mdll_pkg::reg_data_t st;
    reg_write(mdll_pkg::REG_CTRL, 8'h00);      // stop, lock clears
    reg_write(mdll_pkg::REG_GAIN, 8'(g));
    reg_write(mdll_pkg::REG_MAN_CODE, 8'(start));
    use_noise = 1'b0;
    per       = period;
    reg_write(mdll_pkg::REG_CTRL, 8'h03);      // preload above half a period
    wait_cycles(4);
    reg_write(mdll_pkg::REG_CTRL, 8'h01);      // closed loop
    wait_lock(60 * period);
    reg_read(mdll_pkg::REG_STATUS, st);
    check_val("status locked", 32'(st[mdll_pkg::STAT_LOCK_BIT]), 32'd1);
    diff = ref_delay(st[5:0]) - period;
    if (diff < 0) begin
      diff = -diff;
    end
    if (diff > 2 * int'(g)) begin
      abort_run("locked code gives a delay too far from the reference period");
    end
  endtask

  task automatic hold_check();
    mdll_pkg::reg_data_t st0;
    mdll_pkg::reg_data_t st;
    reg_write(mdll_pkg::REG_CTRL, 8'h00);      // loop off
    wait_cycles(2);
    check_val("locked", 32'(locked), 32'd0);
    reg_read(mdll_pkg::REG_STATUS, st0);
    check_val("status locked", 32'(st0[mdll_pkg::STAT_LOCK_BIT]), 32'd0);
    for (int k = 0; k < 8; k++) begin
      wait_cycles(per);                        // one reference period
      reg_read(mdll_pkg::REG_STATUS, st);
      check_val("status code", 32'(st[5:0]), 32'(st0[5:0]));
    end
  endtask

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------
  initial begin
    mdll_pkg::reg_data_t rd;
    rst     = 1'b1;
    wr      = 1'b0;
    addr    = mdll_pkg::REG_CTRL;
    wdata   = '0;
    armed   = 1'b0;
    exp_dly = 0;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;

    // reset state
    reg_read(mdll_pkg::REG_CTRL, rd);
    check_val("ctrl", 32'(rd), 32'd0);
    reg_read(mdll_pkg::REG_STATUS, rd);
    check_val("status", 32'(rd), 32'd0);
    reg_read(mdll_pkg::REG_GAIN, rd);
    check_val("gain", 32'(rd), 32'd1);
    check_val("locked", 32'(locked), 32'd0);

    // register rules, loop still off
    reg_write(mdll_pkg::REG_MAN_CODE, 8'hff);
    reg_read(mdll_pkg::REG_MAN_CODE, rd);
    check_val("man_code", 32'(rd), 32'(mdll_pkg::CODE_MAX));  // clamped
    reg_write(mdll_pkg::REG_STATUS, 8'hff);                    // no effect
    reg_read(mdll_pkg::REG_CTRL, rd);
    check_val("ctrl", 32'(rd), 32'd0);
    reg_read(mdll_pkg::REG_MAN_CODE, rd);
    check_val("man_code", 32'(rd), 32'(mdll_pkg::CODE_MAX));
    reg_read(mdll_pkg::REG_GAIN, rd);
    check_val("gain", 32'(rd), 32'd1);
    reg_read(mdll_pkg::REG_STATUS, rd);
    check_val("status", 32'(rd), 32'd0);
    reg_write(mdll_pkg::REG_GAIN, 8'h05);
    reg_read(mdll_pkg::REG_GAIN, rd);
    check_val("gain", 32'(rd), 32'd5);
    reg_write(mdll_pkg::REG_GAIN, 8'h01);

    // manual delay on random streams
    run_manual(6'd0);
    run_manual(6'd5);
    run_manual(6'd17);
    run_manual(6'(mdll_pkg::CODE_MAX));

    // closed loop locking
    run_lock(3'd1, 24, 6'd16);
    run_lock(3'd2, 30, 6'd20);

    // code holds with the loop off
    hold_check();

    $display("All checks passed");
    $finish;
  end

endmodule

// File: flist.f
hdl/mdll_pkg.sv
hdl/mdll_ctl_if.sv
hdl/mdll_dcdl_coarse_single.sv
hdl/mdll_dcdl_coarse.sv
hdl/mdll_dcdl_fine.sv
hdl/mdll_pfd.sv
hdl/mdll_loop_filter.sv
hdl/mdll_cfg_regs.sv
hdl/mdll_core.sv
tb/mdll_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the mdll testbench with verilator, exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f flist.f --top-module mdll_tb -o mdll_sim \
  && ./obj_dir/mdll_sim \
  || exit 1
